// File: cond_loader.f
+incdir+src
src/cond_loader_pkg.sv
src/cond_window_filter.sv
src/cond_seq_tracker.sv
src/cond_field_decoder.sv
src/cond_config_fifo.sv
src/cond_config_loader.sv
bench/cond_config_loader_sva.sv
bench/cond_config_loader_tb.sv

// File: bench/cond_config_loader_tb.sv
// --------------------------------------------------
// Config loader testbench, record model and checks
// --------------------------------------------------
`timescale 1ns/1ps
`include "cond_loader_settings.svh"

module cond_config_loader_tb;

    import cond_loader_pkg::*;

    localparam int ID_RELATIVE    = 1;
    localparam int WIN_START      = ID_RELATIVE * `COND_SEQ_WIDTH;
    // Worst sequence interleaves one foreign word per window word
    localparam int SEQ_CYCLES     = 2 * `COND_SEQ_WIDTH + 8;
    localparam int DRAIN_CYCLES   = `COND_FIFO_DEPTH + 10;
    localparam int STIM_CYCLES    = 5 + 10 + 3 * (2 * SEQ_CYCLES + DRAIN_CYCLES) +
                                    (`COND_FIFO_DEPTH + 2) * SEQ_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

    logic             ap_clk;
    logic             areset_fifo;
    mem_response_t    response_in;
    logic             config_rd_en;
    cond_config_out_t config_out;
    fifo_status_t     fifo_status;
    logic             setup_busy;

    int seed         = 71775;
    int error_count  = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_count  = 0;
    int sva_failures = 0;

    logic [`COND_DATA_WIDTH-1:0] seq_words [`COND_SEQ_WIDTH];
    cond_config_t                exp_q [$];

    cond_config_loader #(
        .ID_RELATIVE (ID_RELATIVE)
    ) cond_config_loader_i (
        .ap_clk       (ap_clk),
        .areset_fifo  (areset_fifo),
        .response_in  (response_in),
        .config_rd_en (config_rd_en),
        .config_out   (config_out),
        .fifo_status  (fifo_status),
        .setup_busy   (setup_busy)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // --------------------------------------------------
    // Reference model and comparison
    // --------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        error_count++;
    endtask

    // Record as the decode table builds it from the sent words
    function automatic cond_config_t model_record();
        cond_config_t rec;
        rec.operation              = seq_words[0][`COND_OP_WIDTH-1:0];
        rec.filter_mask            = seq_words[1][`COND_NUM_FIELDS-1:0];
        rec.const_mask             = seq_words[2][`COND_NUM_FIELDS-1:0];
        rec.const_value            = seq_words[3];
        rec.ops_mask               = seq_words[4][`COND_NUM_FIELDS*`COND_NUM_FIELDS-1:0];
        rec.flags.break_flag       = seq_words[5][0];
        rec.flags.break_pass       = seq_words[5][1];
        rec.flags.filter_post      = seq_words[5][2];
        rec.flags.filter_pass      = seq_words[5][3];
        rec.flags.continue_flag    = seq_words[5][4];
        rec.flags.ternary_flag     = seq_words[5][5];
        rec.flags.conditional_flag = seq_words[5][6];
        rec.route_if.id_cu         = seq_words[6][3:0];
        rec.route_if.id_bundle     = seq_words[6][7:4];
        rec.route_if.id_lane       = seq_words[6][11:8];
        rec.route_else.id_cu       = seq_words[7][3:0];
        rec.route_else.id_bundle   = seq_words[7][7:4];
        rec.route_else.id_lane     = seq_words[7][11:8];
        rec.route_if.id_engine     = seq_words[8][3:0];
        rec.route_if.id_module     = seq_words[8][7:4];
        rec.route_else.id_engine   = seq_words[8][11:8];
        rec.route_else.id_module   = seq_words[8][15:12];
        return rec;
    endfunction

    task automatic compare_route(input string prefix, input cond_route_t got,
                                 input cond_route_t exp);
        assert (got.id_cu == exp.id_cu)
            else report_mismatch({prefix, ".id_cu"}, got.id_cu, exp.id_cu);
        assert (got.id_bundle == exp.id_bundle)
            else report_mismatch({prefix, ".id_bundle"}, got.id_bundle, exp.id_bundle);
        assert (got.id_lane == exp.id_lane)
            else report_mismatch({prefix, ".id_lane"}, got.id_lane, exp.id_lane);
        assert (got.id_engine == exp.id_engine)
            else report_mismatch({prefix, ".id_engine"}, got.id_engine, exp.id_engine);
        assert (got.id_module == exp.id_module)
            else report_mismatch({prefix, ".id_module"}, got.id_module, exp.id_module);
    endtask

    task automatic compare_record(input cond_config_t got, input cond_config_t exp);
        assert (got.operation == exp.operation)
            else report_mismatch("config_out.operation", got.operation, exp.operation);
        assert (got.filter_mask == exp.filter_mask)
            else report_mismatch("config_out.filter_mask", got.filter_mask, exp.filter_mask);
        assert (got.const_mask == exp.const_mask)
            else report_mismatch("config_out.const_mask", got.const_mask, exp.const_mask);
        assert (got.const_value == exp.const_value)
            else report_mismatch("config_out.const_value", got.const_value, exp.const_value);
        assert (got.ops_mask == exp.ops_mask)
            else report_mismatch("config_out.ops_mask", got.ops_mask, exp.ops_mask);
        assert (got.flags == exp.flags)
            else report_mismatch("config_out.flags", got.flags, exp.flags);
        compare_route("config_out.route_if", got.route_if, exp.route_if);
        compare_route("config_out.route_else", got.route_else, exp.route_else);
    endtask

    // Output is stable at the falling edge
    always @(negedge ap_clk) begin
        cond_config_t expected;
        if (config_out.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected record on config_out at %0t ns", $time);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                compare_record(config_out.payload, expected);
            end
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic fill_words();
        for (int i = 0; i < `COND_SEQ_WIDTH; i++) begin
            seq_words[i] = $random(seed);
        end
    endtask

    // A full FIFO drops the record
    task automatic expect_record();
        if (exp_q.size() < `COND_FIFO_DEPTH) begin
            exp_q.push_back(model_record());
        end
    endtask

    task automatic drive_word(input logic [`COND_OFFSET_WIDTH-1:0] offset,
                              input logic [`COND_DATA_WIDTH-1:0] data);
        @(posedge ap_clk);
        #1;
        response_in.valid  = 1'b1;
        response_in.offset = offset;
        response_in.data   = data;
    endtask

    task automatic drive_idle();
        @(posedge ap_clk);
        #1;
        response_in.valid = 1'b0;
    endtask

    function automatic logic [`COND_OFFSET_WIDTH-1:0] foreign_offset();
        logic [`COND_OFFSET_WIDTH-1:0] off;
        off = $random(seed);
        if (off >= WIN_START && off < WIN_START + `COND_SEQ_WIDTH) begin
            off = off + 8'd32;
        end
        return off;
    endfunction

    task automatic send_sequence(input bit mix_foreign);
        for (int i = 0; i < `COND_SEQ_WIDTH; i++) begin
            drive_word(8'(WIN_START + i), seq_words[i]);
            if (mix_foreign) begin
                drive_word(foreign_offset(), $random(seed));
            end
        end
        drive_idle();
    endtask

    task automatic drain_records();
        int waited;
        waited = 0;
        @(posedge ap_clk);
        #1;
        config_rd_en = 1'b1;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge ap_clk);
            waited++;
        end
        #1;
        config_rd_en = 1'b0;
        assert (exp_q.size() == 0) else begin
            $display("Drain gave up with %0d records never returned", exp_q.size());
            error_count++;
            exp_q.delete();
        end
        repeat (2) @(posedge ap_clk);
        #1;
        assert (fifo_status.empty === 1'b1)
            else report_mismatch("fifo_status.empty", fifo_status.empty, 1'b1);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count != test_errors) begin
            tests_failed++;
            $display("Test %0d %s: failed, %0d errors", tests_run, name,
                     error_count - test_errors);
        end else begin
            $display("Test %0d %s: ok", tests_run, name);
        end
        test_errors = error_count;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int waited;
        int held;
        areset_fifo  = 1'b1;
        config_rd_en = 1'b0;
        response_in  = '0;
        repeat (5) @(posedge ap_clk);
        #1;
        areset_fifo = 1'b0;

        assert (config_out.valid === 1'b0)
            else report_mismatch("config_out.valid", config_out.valid, 1'b0);
        assert (fifo_status.empty === 1'b1)
            else report_mismatch("fifo_status.empty", fifo_status.empty, 1'b1);
        assert (fifo_status.full === 1'b0)
            else report_mismatch("fifo_status.full", fifo_status.full, 1'b0);
        assert (fifo_status.prog_full === 1'b0)
            else report_mismatch("fifo_status.prog_full", fifo_status.prog_full, 1'b0);
        waited = 0;
        while (setup_busy !== 1'b0 && waited < `COND_RST_BUSY_CYCLES + 2) begin
            @(posedge ap_clk);
            #1;
            waited++;
        end
        assert (setup_busy === 1'b0) else begin
            $display("setup_busy still high %0d cycles after reset release", waited);
            error_count++;
        end
        finish_test("reset state");

        fill_words();
        expect_record();
        send_sequence(1'b0);
        drain_records();
        finish_test("single random sequence");

        fill_words();
        expect_record();
        send_sequence(1'b1);
        drain_records();
        finish_test("foreign offsets ignored");

        // Stray window words while idle, none at the window start
        for (int i = 1; i < 5; i++) begin
            drive_word(8'(WIN_START + i), $random(seed));
        end
        drive_idle();
        fill_words();
        expect_record();
        send_sequence(1'b0);
        drain_records();
        finish_test("idle window words ignored");

        for (int s = 0; s < `COND_FIFO_DEPTH + 2; s++) begin
            fill_words();
            expect_record();
            send_sequence(1'b0);
            // Record lands 4 cycles after the last strobe
            repeat (5) @(posedge ap_clk);
            #1;
            held = exp_q.size();
            assert (fifo_status.prog_full === (held >= `COND_PROG_THRESH))
                else report_mismatch("fifo_status.prog_full", fifo_status.prog_full,
                                     held >= `COND_PROG_THRESH);
            assert (fifo_status.full === (held == `COND_FIFO_DEPTH))
                else report_mismatch("fifo_status.full", fifo_status.full,
                                     held == `COND_FIFO_DEPTH);
            assert (fifo_status.empty === 1'b0)
                else report_mismatch("fifo_status.empty", fifo_status.empty, 1'b0);
        end
        drain_records();
        finish_test("fill to full and drain");

        sva_failures = cond_config_loader_i.cond_config_fifo_i.cond_config_fifo_sva_i.fail_count;
        error_count += sva_failures;
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, sva_failures);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: bench/cond_config_loader_sva.sv
// --------------------------------------------------
// FIFO protocol assertions, bound to the config FIFO
// --------------------------------------------------
`timescale 1ns/1ps
`include "cond_loader_settings.svh"

module cond_config_fifo_sva (
    input logic                              ap_clk,
    input logic                              areset_fifo,
    input logic                              push_valid,
    input logic                              config_rd_en,
    input cond_loader_pkg::cond_config_out_t config_out,
    input cond_loader_pkg::fifo_status_t     fifo_status,
    input logic                              setup_busy,
    input logic [$clog2(`COND_FIFO_DEPTH):0] fifo_count
);

    import cond_loader_pkg::*;

    int fail_count = 0;

    // Each valid pulse takes one record out of storage
    valid_after_pop: assert property (@(posedge ap_clk) disable iff (areset_fifo)
        config_out.valid |-> $past(config_rd_en) &&
            ((fifo_count + 1 == $past(fifo_count)) || $past(push_valid)))
        else begin
            $error("config_out.valid pulsed without a record leaving the FIFO");
            fail_count++;
        end

    // Refused push leaves the occupancy unchanged
    dropped_push_holds_count: assert property (@(posedge ap_clk) disable iff (areset_fifo)
        (push_valid && (fifo_status.full || setup_busy) &&
         !(config_rd_en && !fifo_status.empty && !setup_busy)) |=> $stable(fifo_count))
        else begin
            $error("FIFO count changed on a dropped push");
            fail_count++;
        end

    empty_full_exclusive: assert property (@(posedge ap_clk) disable iff (areset_fifo)
        !(fifo_status.empty && fifo_status.full))
        else begin
            $error("FIFO reports empty and full at once");
            fail_count++;
        end

    // Busy for the whole window after reset release
    busy_after_reset: assert property (@(posedge ap_clk)
        $fell(areset_fifo) |-> setup_busy [*`COND_RST_BUSY_CYCLES])
        else begin
            $error("setup_busy dropped inside the reset-busy window");
            fail_count++;
        end

endmodule

bind cond_config_fifo cond_config_fifo_sva cond_config_fifo_sva_i (
    .ap_clk       (ap_clk),
    .areset_fifo  (areset_fifo),
    .push_valid   (push_valid),
    .config_rd_en (config_rd_en),
    .config_out   (config_out),
    .fifo_status  (fifo_status),
    .setup_busy   (setup_busy),
    .fifo_count   (fifo_count)
);

// File: src/cond_config_loader.sv
// -----------------------------------------------
// Filter-condition config loader top level
// -----------------------------------------------
`timescale 1ns/1ps
`include "cond_loader_settings.svh"

module cond_config_loader #(
    parameter int ID_RELATIVE = 0
) (
    input  logic                              ap_clk,
    input  logic                              areset_fifo,
    input  cond_loader_pkg::mem_response_t    response_in,
    input  logic                              config_rd_en,
    output cond_loader_pkg::cond_config_out_t config_out,
    output cond_loader_pkg::fifo_status_t     fifo_status,
    output logic                              setup_busy
);

    import cond_loader_pkg::*;

    // Filter to tracker and decoder
    logic                               word_valid;
    logic                               word_first;
    logic [`COND_DATA_WIDTH-1:0]        word_data;

    // Tracker to decoder
    logic [$clog2(`COND_SEQ_WIDTH)-1:0] word_index;
    logic                               index_valid;
    logic                               seq_done;

    // Decoder to FIFO
    logic                               push_valid;
    cond_config_t                       push_config;

    cond_window_filter #(
        .ID_RELATIVE (ID_RELATIVE)
    ) cond_window_filter_i (
        .ap_clk      (ap_clk),
        .areset_fifo (areset_fifo),
        .response_in (response_in),
        .word_valid  (word_valid),
        .word_first  (word_first),
        .word_data   (word_data)
    );

    cond_seq_tracker cond_seq_tracker_i (
        .ap_clk      (ap_clk),
        .areset_fifo (areset_fifo),
        .word_valid  (word_valid),
        .word_first  (word_first),
        .word_index  (word_index),
        .index_valid (index_valid),
        .seq_done    (seq_done)
    );

    cond_field_decoder cond_field_decoder_i (
        .ap_clk      (ap_clk),
        .areset_fifo (areset_fifo),
        .word_data   (word_data),
        .word_index  (word_index),
        .index_valid (index_valid),
        .seq_done    (seq_done),
        .push_valid  (push_valid),
        .push_config (push_config)
    );

    cond_config_fifo cond_config_fifo_i (
        .ap_clk       (ap_clk),
        .areset_fifo  (areset_fifo),
        .push_valid   (push_valid),
        .push_config  (push_config),
        .config_rd_en (config_rd_en),
        .config_out   (config_out),
        .fifo_status  (fifo_status),
        .setup_busy   (setup_busy)
    );

endmodule

// File: src/cond_config_fifo.sv
// -----------------------------------------------
// Config record FIFO with status and reset-busy
// -----------------------------------------------
`timescale 1ns/1ps
`include "cond_loader_settings.svh"

module cond_config_fifo (
    input  logic                              ap_clk,
    input  logic                              areset_fifo,
    input  logic                              push_valid,
    input  cond_loader_pkg::cond_config_t     push_config,
    input  logic                              config_rd_en,
    output cond_loader_pkg::cond_config_out_t config_out,
    output cond_loader_pkg::fifo_status_t     fifo_status,
    output logic                              setup_busy
);

    import cond_loader_pkg::*;

    localparam int PTR_W  = $clog2(`COND_FIFO_DEPTH);
    localparam int CNT_W  = PTR_W + 1;
    localparam int BUSY_W = $clog2(`COND_RST_BUSY_CYCLES + 1);

    cond_config_t      fifo_mem [`COND_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fifo_count;
    logic [BUSY_W-1:0] busy_count;
    logic              push_accept;
    logic              pop_accept;

    // ------------------------------------------------
    // Reset-busy window
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            busy_count <= BUSY_W'(`COND_RST_BUSY_CYCLES);
        end else if (busy_count != '0) begin
            busy_count <= busy_count - 1'b1;
        end
    end

    assign setup_busy = (busy_count != '0);

    // Flags come straight from the occupancy count
    assign fifo_status.empty     = (fifo_count == '0);
    assign fifo_status.full      = (fifo_count == CNT_W'(`COND_FIFO_DEPTH));
    assign fifo_status.prog_full = (fifo_count >= CNT_W'(`COND_PROG_THRESH));

    // Push when full or busy is lost, read enable is sampled at this edge
    assign push_accept = push_valid & ~fifo_status.full & ~setup_busy;
    assign pop_accept  = config_rd_en & ~fifo_status.empty & ~setup_busy;

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (push_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_accept, pop_accept})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push_accept) begin
            fifo_mem[wr_ptr] <= push_config;
        end
    end

    // Registered read port, valid pulses once per pop
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            config_out.valid <= 1'b0;
        end else begin
            config_out.valid <= pop_accept;
        end
        if (pop_accept) begin
            config_out.payload <= fifo_mem[rd_ptr];
        end
    end

endmodule

// File: src/cond_field_decoder.sv
// -----------------------------------------------
// Per-index decode of words into one config record
// -----------------------------------------------
`timescale 1ns/1ps
`include "cond_loader_settings.svh"

module cond_field_decoder (
    input  logic                                ap_clk,
    input  logic                                areset_fifo,
    input  logic [`COND_DATA_WIDTH-1:0]         word_data,
    input  logic [$clog2(`COND_SEQ_WIDTH)-1:0]  word_index,
    input  logic                                index_valid,
    input  logic                                seq_done,
    output logic                                push_valid,
    output cond_loader_pkg::cond_config_t       push_config
);

    import cond_loader_pkg::*;

    localparam int OPS_W = `COND_NUM_FIELDS * `COND_NUM_FIELDS;

    // Word delayed one cycle to meet its index from the tracker
    logic [`COND_DATA_WIDTH-1:0] word_delay;
    cond_word_u                  word_view;
    cond_config_t                config_reg;

    always_ff @(posedge ap_clk) begin
        word_delay <= word_data;
    end

    assign word_view = word_delay;

    // ------------------------------------------------
    // Field decode
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (index_valid) begin
            case (word_index)
                0: begin
                    config_reg.operation <= word_delay[`COND_OP_WIDTH-1:0];
                end
                1: begin
                    config_reg.filter_mask <= word_delay[`COND_NUM_FIELDS-1:0];
                end
                2: begin
                    config_reg.const_mask <= word_delay[`COND_NUM_FIELDS-1:0];
                end
                3: begin
                    config_reg.const_value <= word_delay;
                end
                4: begin
                    config_reg.ops_mask <= word_delay[OPS_W-1:0];
                end
                5: begin
                    config_reg.flags <= word_view.flags_view.flags;
                end
                6: begin
                    config_reg.route_if.id_cu     <= word_view.route_view.id_cu;
                    config_reg.route_if.id_bundle <= word_view.route_view.id_bundle;
                    config_reg.route_if.id_lane   <= word_view.route_view.id_lane;
                end
                7: begin
                    config_reg.route_else.id_cu     <= word_view.route_view.id_cu;
                    config_reg.route_else.id_bundle <= word_view.route_view.id_bundle;
                    config_reg.route_else.id_lane   <= word_view.route_view.id_lane;
                end
                // Engine and module IDs of both routes share one word
                8: begin
                    config_reg.route_if.id_engine   <= word_view.engine_view.if_engine;
                    config_reg.route_if.id_module   <= word_view.engine_view.if_module;
                    config_reg.route_else.id_engine <= word_view.engine_view.else_engine;
                    config_reg.route_else.id_module <= word_view.engine_view.else_module;
                end
                // Words 9 to 15 are reserved
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------
    // Record hand-off to the FIFO
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= seq_done;
        end
        if (seq_done) begin
            push_config <= config_reg;
        end
    end

endmodule

// File: src/cond_seq_tracker.sv
// -----------------------------------------------
// Word counter for one configuration sequence
// -----------------------------------------------
`timescale 1ns/1ps
`include "cond_loader_settings.svh"

module cond_seq_tracker (
    input  logic                                ap_clk,
    input  logic                                areset_fifo,
    input  logic                                word_valid,
    input  logic                                word_first,
    output logic [$clog2(`COND_SEQ_WIDTH)-1:0]  word_index,
    output logic                                index_valid,
    output logic                                seq_done
);

    localparam int               IDX_W      = $clog2(`COND_SEQ_WIDTH);
    localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(`COND_SEQ_WIDTH - 1);

    logic             seq_active;
    // Index the next in-window word will take
    logic [IDX_W-1:0] word_count;

    // ------------------------------------------------
    // Sequence start, advance and completion
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            seq_active  <= 1'b0;
            word_count  <= '0;
            word_index  <= '0;
            index_valid <= 1'b0;
            seq_done    <= 1'b0;
        end else begin
            index_valid <= 1'b0;
            seq_done    <= 1'b0;
            if (word_valid) begin
                if (seq_active) begin
                    word_index  <= word_count;
                    index_valid <= 1'b1;
                    word_count  <= word_count + 1'b1;
                    // Last word closes the sequence, counter wraps to 0
                    if (word_count == LAST_INDEX) begin
                        seq_active <= 1'b0;
                        seq_done   <= 1'b1;
                    end
                end else if (word_first) begin
                    word_index  <= '0;
                    index_valid <= 1'b1;
                    word_count  <= IDX_W'(1);
                    seq_active  <= 1'b1;
                end
                // Idle and not at window start, word is dropped
            end
        end
    end

endmodule

// File: src/cond_window_filter.sv
// -----------------------------------------------
// Response input register and offset-window test
// -----------------------------------------------
`timescale 1ns/1ps
`include "cond_loader_settings.svh"

module cond_window_filter #(
    parameter int ID_RELATIVE = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset_fifo,
    input  cond_loader_pkg::mem_response_t response_in,
    output logic                           word_valid,
    output logic                           word_first,
    output logic [`COND_DATA_WIDTH-1:0]    word_data
);

    import cond_loader_pkg::*;

    // Window covers SEQ_MIN up to but not including SEQ_MAX
    localparam int SEQ_MIN = ID_RELATIVE * `COND_SEQ_WIDTH;
    localparam int SEQ_MAX = SEQ_MIN + `COND_SEQ_WIDTH;

    mem_response_t response_reg;
    logic          in_window;

    // Only the strobe is cleared, offset and data just follow
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            response_reg.valid <= 1'b0;
        end else begin
            response_reg.valid <= response_in.valid;
        end
        response_reg.offset <= response_in.offset;
        response_reg.data   <= response_in.data;
    end

    assign in_window = (int'(response_reg.offset) >= SEQ_MIN) &&
                       (int'(response_reg.offset) < SEQ_MAX);

    assign word_valid = response_reg.valid & in_window;
    assign word_first = word_valid & (int'(response_reg.offset) == SEQ_MIN);
    assign word_data  = response_reg.data;

endmodule

// File: src/cond_loader_pkg.sv
// -----------------------------------------------
// Response, configuration and status types
// Data-word union with flags, route, engine views
// -----------------------------------------------
`include "cond_loader_settings.svh"

package cond_loader_pkg;

    typedef struct packed {
        logic                          valid;
        logic [`COND_OFFSET_WIDTH-1:0] offset;
        logic [`COND_DATA_WIDTH-1:0]   data;
    } mem_response_t;

    typedef struct packed {
        logic [`COND_CU_BITS-1:0]     id_cu;
        logic [`COND_BUNDLE_BITS-1:0] id_bundle;
        logic [`COND_LANE_BITS-1:0]   id_lane;
        logic [`COND_ENGINE_BITS-1:0] id_engine;
        logic [`COND_MODULE_BITS-1:0] id_module;
    } cond_route_t;

    // Last member sits at bit 0
    typedef struct packed {
        logic conditional_flag;
        logic ternary_flag;
        logic continue_flag;
        logic filter_pass;
        logic filter_post;
        logic break_pass;
        logic break_flag;
    } cond_flags_t;

    // ------------------------------------------------
    // Views of one configuration data word
    // ------------------------------------------------
    typedef struct packed {
        logic [`COND_DATA_WIDTH-$bits(cond_flags_t)-1:0] unused;
        cond_flags_t                                     flags;
    } cond_flags_view_t;

    typedef struct packed {
        logic [`COND_DATA_WIDTH-`COND_CU_BITS-`COND_BUNDLE_BITS-`COND_LANE_BITS-1:0] unused;
        logic [`COND_LANE_BITS-1:0]   id_lane;
        logic [`COND_BUNDLE_BITS-1:0] id_bundle;
        logic [`COND_CU_BITS-1:0]     id_cu;
    } cond_route_view_t;

    typedef struct packed {
        logic [`COND_DATA_WIDTH-2*(`COND_ENGINE_BITS+`COND_MODULE_BITS)-1:0] unused;
        logic [`COND_MODULE_BITS-1:0] else_module;
        logic [`COND_ENGINE_BITS-1:0] else_engine;
        logic [`COND_MODULE_BITS-1:0] if_module;
        logic [`COND_ENGINE_BITS-1:0] if_engine;
    } cond_engine_view_t;

    typedef union packed {
        cond_flags_view_t  flags_view;
        cond_route_view_t  route_view;
        cond_engine_view_t engine_view;
    } cond_word_u;

    // ------------------------------------------------
    // Configuration record and loader outputs
    // ------------------------------------------------
    typedef struct packed {
        logic [`COND_OP_WIDTH-1:0]                      operation;
        logic [`COND_NUM_FIELDS-1:0]                    filter_mask;
        logic [`COND_NUM_FIELDS-1:0]                    const_mask;
        logic [`COND_DATA_WIDTH-1:0]                    const_value;
        logic [`COND_NUM_FIELDS*`COND_NUM_FIELDS-1:0]   ops_mask;
        cond_flags_t                                    flags;
        cond_route_t                                    route_if;
        cond_route_t                                    route_else;
    } cond_config_t;

    typedef struct packed {
        logic         valid;
        cond_config_t payload;
    } cond_config_out_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
    } fifo_status_t;

endpackage

// File: src/cond_loader_settings.svh
// -----------------------------------------------
// Widths, FIFO depth and reset-busy length
// -----------------------------------------------
`ifndef COND_LOADER_SETTINGS_SVH
`define COND_LOADER_SETTINGS_SVH

// Sequence geometry and data word
`define COND_SEQ_WIDTH        16
`define COND_DATA_WIDTH       32
`define COND_OFFSET_WIDTH     8
`define COND_NUM_FIELDS       4
`define COND_OP_WIDTH         4

// Output FIFO
`define COND_FIFO_DEPTH       16
`define COND_PROG_THRESH      8
`define COND_RST_BUSY_CYCLES  4

// Route ID field widths
`define COND_CU_BITS          4
`define COND_BUNDLE_BITS      4
`define COND_LANE_BITS        4
`define COND_ENGINE_BITS      4
`define COND_MODULE_BITS      4

`endif
